// File: rtl/video_timing_pkg.sv
`default_nettype none

package video_timing_pkg;

	localparam int x_w = 10; // pixel counter width
	localparam int y_w = 9;  // line counter width

	// one flag set per pixel step, positions held until the next fetch
	typedef struct packed {
		logic           pix_stb;     // one pixel step
		logic           active;      // pixel is visible
		logic           line_start;  // first visible pixel of a line
		logic           frame_start; // first visible pixel of a frame
		logic           fetch_sync;  // first pixel of a 32-pixel chunk
		logic           fetch_req;   // start fetching the next chunk
		logic           int_start;   // first blank line after the picture
		logic [4:0]     fetch_col;   // chunk column to fetch
		logic [y_w-1:0] fetch_row;   // picture row to fetch
	} timing_strobes_t;

endpackage

`default_nettype wire

// File: rtl/video_data_pkg.sv
`default_nettype none

package video_data_pkg;

	typedef struct packed {
		logic bright;
		logic g;
		logic r;
		logic b;
	} color_t;

	// spectrum attribute byte
	typedef struct packed {
		logic       flash;
		logic       bright;
		logic [2:0] paper; // g, r, b
		logic [2:0] ink;   // g, r, b
	} attr_t;

	typedef struct packed {
		logic        rd;   // single-cycle read strobe
		logic [15:0] addr; // byte address
	} mem_req_t;

	typedef enum logic [1:0] {
		idle,
		issue,
		wait_data,
		done
	} fetch_state_e;

	typedef struct packed {
		logic   valid;
		logic   line_start;
		logic   frame_start;
		color_t color;
	} video_out_t;

endpackage

`default_nettype wire

// File: rtl/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
	parameter int h_active    = 64,
	parameter int h_total     = 128,
	parameter int v_active    = 16,
	parameter int v_total     = 20,
	parameter int clk_per_pix = 2
) (
	input  logic                              clk,
	input  logic                              reset,
	output video_timing_pkg::timing_strobes_t timing
);

	import video_timing_pkg::*;

	localparam int pre_w = (clk_per_pix > 1) ? $clog2(clk_per_pix) : 1;

	localparam logic [pre_w-1:0] pre_last   = pre_w'(clk_per_pix - 1);
	localparam logic [x_w-1:0]   x_last     = x_w'(h_total - 1);
	localparam logic [x_w-1:0]   x_act      = x_w'(h_active);
	localparam logic [x_w-1:0]   x_prefetch = x_w'(h_total - 32);
	localparam logic [x_w-1:0]   x_mid_end  = x_w'(h_active - 32);
	localparam logic [y_w-1:0]   y_last     = y_w'(v_total - 1);
	localparam logic [y_w-1:0]   y_act      = y_w'(v_active);
	localparam logic [y_w-1:0]   y_act_last = y_w'(v_active - 1);

	logic [pre_w-1:0] pre_cnt;
	logic [x_w-1:0]   x_cnt;
	logic [y_w-1:0]   y_cnt;
	logic             tick;
	logic             at_x0;
	logic             vis_line;
	logic             vis;
	logic             chunk_edge;
	logic             pre_fetch;
	logic             mid_fetch;
	logic [4:0]       next_col;
	logic [y_w-1:0]   next_row;

	assign tick       = (pre_cnt == pre_last);
	assign at_x0      = (x_cnt == '0);
	assign vis_line   = (y_cnt < y_act);
	assign vis        = vis_line & (x_cnt < x_act);
	assign chunk_edge = (x_cnt[4:0] == 5'd0);

	// chunk 0 of the next line is fetched in horizontal blanking
	assign pre_fetch = (x_cnt == x_prefetch);
	// chunk c+1 is fetched while chunk c is on screen
	assign mid_fetch = vis_line & chunk_edge & (x_cnt < x_mid_end);
	assign next_col  = 5'(x_cnt[x_w-1:5]) + 5'd1;
	assign next_row  = (y_cnt >= y_act_last) ? '0 : y_cnt + 1'b1; // wrap after last row

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pre_cnt <= '0;
			x_cnt   <= '0;
			y_cnt   <= '0;
		end
		else
		begin
			pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
			if (tick)
			begin
				if (x_cnt == x_last)
				begin
					x_cnt <= '0;
					y_cnt <= (y_cnt == y_last) ? '0 : y_cnt + 1'b1;
				end
				else
				begin
					x_cnt <= x_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			timing <= '0;
		end
		else
		begin
			timing.pix_stb     <= tick;
			timing.line_start  <= tick & vis_line & at_x0;
			timing.frame_start <= tick & at_x0 & (y_cnt == '0);
			timing.fetch_sync  <= tick & vis & chunk_edge;
			timing.fetch_req   <= tick & (pre_fetch | mid_fetch);
			timing.int_start   <= tick & at_x0 & (y_cnt == y_act);
			if (tick)
				timing.active <= vis;
			if (tick & pre_fetch)
			begin
				timing.fetch_col <= 5'd0;
				timing.fetch_row <= next_row;
			end
			else if (tick & mid_fetch)
			begin
				timing.fetch_col <= next_col;
				timing.fetch_row <= y_cnt;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/video_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module video_fetch #(
	parameter int          h_active  = 64,
	parameter logic [15:0] attr_base = 16'h1800
) (
	input  logic                              clk,
	input  logic                              reset,
	input  video_timing_pkg::timing_strobes_t timing,
	output video_data_pkg::mem_req_t          mem_req,
	input  logic                              rd_valid,
	input  logic [7:0]                        rd_data,
	output logic [63:0]                       pic_bits
);

	import video_data_pkg::*;

	localparam logic [15:0] bytes_per_line = 16'(h_active / 8);

	fetch_state_e state;
	logic [2:0]   issue_idx; // bit 0 selects attr, bits 2:1 the group
	logic [2:0]   ret_idx;
	logic [2:0]   ret_lane;
	logic [15:0]  col_off;
	logic [15:0]  pix_addr;
	logic [15:0]  attr_addr;
	logic [63:0]  fetch_buf;
	logic [63:0]  shown_bits;
	logic         start;

	assign start   = (state == idle) & timing.fetch_req;
	assign col_off = {9'd0, timing.fetch_col, 2'b00}; // col8 of group 0

	// pixel byte of group g to lane {g0,0,g1}, attr byte to {g0,1,g1}
	assign ret_lane = {ret_idx[1], ret_idx[0], ret_idx[2]};

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			pix_addr  <= 16'(timing.fetch_row) * bytes_per_line + col_off;
			attr_addr <= attr_base + 16'(timing.fetch_row >> 3) * bytes_per_line + col_off;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state     <= idle;
			issue_idx <= '0;
			mem_req   <= '0;
		end
		else
		begin
			mem_req.rd <= 1'b0;
			case (state)
				idle:
				begin
					if (timing.fetch_req)
					begin
						issue_idx <= '0;
						state     <= issue;
					end
				end
				issue:
				begin
					mem_req.rd   <= 1'b1;
					mem_req.addr <= (issue_idx[0] ? attr_addr : pix_addr)
						+ 16'(issue_idx[2:1]);
					issue_idx    <= issue_idx + 1'b1;
					state        <= wait_data;
				end
				wait_data:
				begin
					if (rd_valid)
						state <= (ret_idx == 3'd7) ? done : issue; // one read in flight
				end
				done:
				begin
					state <= idle;
				end
				default:
				begin
					state <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			ret_idx <= '0;
		else if (start)
			ret_idx <= '0;
		else if (rd_valid)
			ret_idx <= ret_idx + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (rd_valid)
			fetch_buf[{ret_lane, 3'b000} +: 8] <= rd_data;
		if (timing.fetch_sync)
			shown_bits <= fetch_buf;
	end

	// first pixel of a chunk already sees the new buffer
	assign pic_bits = timing.fetch_sync ? fetch_buf : shown_bits;

endmodule

`default_nettype wire

// File: rtl/video_render.sv
`timescale 1ns/1ps
`default_nettype none

module video_render (
	input  logic                              clk,
	input  logic                              reset,
	input  video_timing_pkg::timing_strobes_t timing,
	input  logic [63:0]                       pic_bits,
	output video_data_pkg::video_out_t        pix_out
);

	import video_data_pkg::*;

	logic [2:0] pnum; // pixel in group
	logic [1:0] gnum; // group in chunk
	logic [2:0] cur_p;
	logic [1:0] cur_g;
	logic [2:0] pix_lane;
	logic [2:0] attr_lane;
	logic [7:0] pix_byte;
	attr_t      attr;
	logic [4:0] flash_ctr;
	logic       pix_bit;
	logic       step;
	color_t     color;
	logic       out_valid;
	logic       out_line;
	logic       out_frame;
	color_t     out_color;

	assign step  = timing.pix_stb & timing.active;
	assign cur_p = timing.fetch_sync ? 3'd0 : pnum; // chunk restarts at pixel 0
	assign cur_g = timing.fetch_sync ? 2'd0 : gnum;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pnum <= '0;
			gnum <= '0;
		end
		else if (step)
		begin
			pnum <= cur_p + 1'b1;
			gnum <= (cur_p == 3'd7) ? cur_g + 1'b1 : cur_g;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			flash_ctr <= '0;
		else if (timing.int_start)
			flash_ctr <= flash_ctr + 1'b1; // once per frame
	end

	assign pix_lane  = {cur_g[0], 1'b0, cur_g[1]};
	assign attr_lane = {cur_g[0], 1'b1, cur_g[1]};
	assign pix_byte  = pic_bits[{pix_lane, 3'b000} +: 8];
	assign attr      = attr_t'(pic_bits[{attr_lane, 3'b000} +: 8]);
	assign pix_bit   = pix_byte[~cur_p] ^ (attr.flash & flash_ctr[4]); // msb drawn first

	always_comb
	begin
		color.bright = attr.bright;
		{color.g, color.r, color.b} = pix_bit ? attr.ink : attr.paper;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			out_line  <= 1'b0;
			out_frame <= 1'b0;
		end
		else
		begin
			out_valid <= step;
			out_line  <= timing.line_start;
			out_frame <= timing.frame_start;
		end
	end

	always_ff @(posedge clk)
	begin
		if (step)
			out_color <= color;
	end

	assign pix_out = '{valid: out_valid, line_start: out_line, frame_start: out_frame,
		color: out_color};

endmodule

`default_nettype wire

// File: rtl/video_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_top #(
	parameter int          h_active    = 64,
	parameter int          h_total     = 128,
	parameter int          v_active    = 16,
	parameter int          v_total     = 20,
	parameter int          clk_per_pix = 2,
	parameter logic [15:0] attr_base   = 16'h1800
) (
	input  logic                       clk,
	input  logic                       reset,
	output video_data_pkg::mem_req_t   mem_req,
	input  logic                       rd_valid,
	input  logic [7:0]                 rd_data,
	output video_data_pkg::video_out_t pix_out
);

	import video_timing_pkg::*;

	timing_strobes_t timing;
	logic [63:0]     pic_bits; // chunk on screen

	video_timing #(
		.h_active    (h_active),
		.h_total     (h_total),
		.v_active    (v_active),
		.v_total     (v_total),
		.clk_per_pix (clk_per_pix)
	) i_video_timing (
		.clk    (clk),
		.reset  (reset),
		.timing (timing)
	);

	video_fetch #(
		.h_active  (h_active),
		.attr_base (attr_base)
	) i_video_fetch (
		.clk      (clk),
		.reset    (reset),
		.timing   (timing),
		.mem_req  (mem_req),
		.rd_valid (rd_valid),
		.rd_data  (rd_data),
		.pic_bits (pic_bits)
	);

	video_render i_video_render (
		.clk      (clk),
		.reset    (reset),
		.timing   (timing),
		.pic_bits (pic_bits),
		.pix_out  (pix_out)
	);

endmodule

`default_nettype wire

// File: verification/video_checker.sv
`timescale 1ns/1ps
`default_nettype none

module video_checker #(
	parameter int          h_active  = 64,
	parameter int          v_active  = 16,
	parameter logic [15:0] attr_base = 16'h1800
) (
	input logic                              clk,
	input logic                              reset,
	input video_data_pkg::mem_req_t          mem_req,
	input video_data_pkg::video_out_t        pix_out,
	input video_timing_pkg::timing_strobes_t timing
);

	import video_data_pkg::*;

	localparam int bpl      = h_active / 8; // bytes per line
	localparam int pix_end  = v_active * bpl;
	localparam int attr_end = int'(attr_base) + ((v_active + 7) / 8) * bpl;

	int         err_count = 0;
	int         x_next;
	int         y_cur;
	int         frame_cur;
	int         line_px;
	int         line_cnt;
	int         rd_cnt;
	logic       line_seen;
	logic       frame_seen;
	logic       req_seen;
	logic       primed; // chunk 0 prefetch has happened
	int         px;
	int         py;
	int         pf;
	logic [7:0] pb;
	logic [7:0] ab;
	logic       exp_bit;
	color_t     exp_color;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		lcg_step = s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [7:0] model_byte(input logic [15:0] addr);
		logic [31:0] s;
		if (addr < attr_base)
			model_byte = 8'((32'(addr) * 32'd37 + 32'd11) % 32'd256);
		else
		begin
			s = lcg_step(32'd6 ^ 32'(addr));
			s = lcg_step(s);
			model_byte = s[23:16];
		end
	endfunction

	always_comb
	begin
		px = pix_out.line_start ? 0 : x_next;
		py = pix_out.frame_start ? 0 : (pix_out.line_start ? y_cur + 1 : y_cur);
		pf = pix_out.frame_start ? frame_cur + 1 : frame_cur;
		pb = model_byte(16'(py * bpl + px / 8));
		ab = model_byte(16'(int'(attr_base) + (py / 8) * bpl + px / 8));
		exp_bit = pb[3'(7 - px % 8)] ^ (ab[7] & ((pf % 32) >= 16)); // bit 7 first
		exp_color = {ab[6], exp_bit ? ab[2:0] : ab[5:3]};
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			x_next     <= 0;
			y_cur      <= 0;
			frame_cur  <= -1; // first frame after reset becomes 0
			line_px    <= 0;
			line_cnt   <= 0;
			rd_cnt     <= 0;
			line_seen  <= 1'b0;
			frame_seen <= 1'b0;
			req_seen   <= 1'b0;
			primed     <= 1'b0;
		end
		else
		begin
			if (pix_out.valid)
			begin
				x_next    <= px + 1;
				y_cur     <= py;
				frame_cur <= pf;
				line_px   <= pix_out.line_start ? 1 : line_px + 1;
				if (pix_out.line_start)
					line_seen <= 1'b1;
				if (pix_out.frame_start)
				begin
					frame_seen <= 1'b1;
					line_cnt   <= 1;
				end
				else if (pix_out.line_start)
					line_cnt <= line_cnt + 1;
			end
			if (timing.fetch_req)
			begin
				req_seen <= 1'b1;
				rd_cnt   <= mem_req.rd ? 1 : 0;
				if (timing.fetch_col == 5'd0)
					primed <= 1'b1;
			end
			else if (mem_req.rd)
				rd_cnt <= rd_cnt + 1;
		end
	end

	a_reset_quiet: assert property (@(posedge clk) reset |=> (!mem_req.rd && !pix_out.valid))
		else
		begin
			$error("read or valid active right after reset");
			err_count++;
		end

	a_addr_range: assert property (@(posedge clk) disable iff (reset)
		mem_req.rd |-> (int'(mem_req.addr) < pix_end
			|| (mem_req.addr >= attr_base && int'(mem_req.addr) < attr_end)))
		else
		begin
			$error("read address %h outside video memory", mem_req.addr);
			err_count++;
		end

	a_eight_reads: assert property (@(posedge clk) disable iff (reset)
		(timing.fetch_req && req_seen) |-> rd_cnt == 8)
		else
		begin
			$error("ERROR %0t rd_cnt got %0d expected 8", $time, rd_cnt);
			err_count++;
		end

	a_line_len: assert property (@(posedge clk) disable iff (reset)
		(pix_out.valid && pix_out.line_start && line_seen) |-> line_px == h_active)
		else
		begin
			$error("ERROR %0t line_px got %0d expected %0d", $time, line_px, h_active);
			err_count++;
		end

	a_frame_len: assert property (@(posedge clk) disable iff (reset)
		(pix_out.valid && pix_out.frame_start && frame_seen) |-> line_cnt == v_active)
		else
		begin
			$error("ERROR %0t line_cnt got %0d expected %0d", $time, line_cnt, v_active);
			err_count++;
		end

	a_flags: assert property (@(posedge clk) disable iff (reset)
		(!pix_out.frame_start || pix_out.line_start)
		&& (!pix_out.line_start || pix_out.valid)
		&& (!(pix_out.valid && !pix_out.line_start) || (line_seen && x_next < h_active)))
		else
		begin
			$error("line_start or frame_start not on the first pixel");
			err_count++;
		end

	a_color_plain: assert property (@(posedge clk) disable iff (reset)
		(pix_out.valid && primed && !ab[7]) |-> pix_out.color == exp_color)
		else
		begin
			$error("ERROR %0t pix_out.color got %h expected %h", $time, pix_out.color,
				exp_color);
			err_count++;
		end

	a_color_flash: assert property (@(posedge clk) disable iff (reset)
		(pix_out.valid && primed && ab[7]) |-> pix_out.color == exp_color)
		else
		begin
			$error("ERROR %0t pix_out.color got %h expected %h (flash)", $time,
				pix_out.color, exp_color);
			err_count++;
		end

endmodule

bind video_top video_checker #(
	.h_active  (h_active),
	.v_active  (v_active),
	.attr_base (attr_base)
) i_video_checker (
	.clk     (clk),
	.reset   (reset),
	.mem_req (mem_req),
	.pix_out (pix_out),
	.timing  (timing)
);

`default_nettype wire

// File: verification/video_tb.sv
`timescale 1ns/1ps
`default_nettype none

module video_tb;

	import video_data_pkg::*;

	localparam int          h_active    = 64;
	localparam int          h_total     = 128;
	localparam int          v_active    = 16;
	localparam int          v_total     = 20;
	localparam int          clk_per_pix = 2;
	localparam logic [15:0] attr_base   = 16'h1800;
	localparam int          run_frames  = 36;

	// 40 frames of 10 ns cycles plus some slack
	localparam longint frame_ns    = longint'(v_total * h_total * clk_per_pix) * 10;
	localparam longint watchdog_ns = 40 * frame_ns + 20000;

	logic        clk;
	logic        reset;
	mem_req_t    mem_req;
	logic        rd_valid;
	logic [7:0]  rd_data;
	video_out_t  pix_out;
	logic        d_valid; // first stage of the read delay
	logic [15:0] d_addr;
	int          frames_seen;
	int          errors;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		lcg_next = s * 32'd1103515245 + 32'd12345;
	endfunction

	// pixel area is address based, attributes are pseudo random
	function automatic logic [7:0] mem_byte(input logic [15:0] addr);
		logic [31:0] s;
		if (addr < attr_base)
			mem_byte = 8'((32'(addr) * 32'd37 + 32'd11) % 32'd256);
		else
		begin
			s = lcg_next(32'd6 ^ 32'(addr)); // seed 6 mixed with address
			s = lcg_next(s);
			mem_byte = s[23:16];
		end
	endfunction

	video_top #(
		.h_active    (h_active),
		.h_total     (h_total),
		.v_active    (v_active),
		.v_total     (v_total),
		.clk_per_pix (clk_per_pix),
		.attr_base   (attr_base)
	) i_video_top (
		.clk      (clk),
		.reset    (reset),
		.mem_req  (mem_req),
		.rd_valid (rd_valid),
		.rd_data  (rd_data),
		.pix_out  (pix_out)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	initial
	begin
		reset    = 1'b1;
		rd_valid = 1'b0;
		rd_data  = 8'd0;
		d_valid  = 1'b0;
		d_addr   = 16'd0;
		repeat (8)
			@(posedge clk);
		reset <= 1'b0;
	end

	// memory answers each read two cycles later
	always @(posedge clk)
	begin
		if (reset)
		begin
			d_valid  <= 1'b0;
			rd_valid <= 1'b0;
		end
		else
		begin
			d_valid  <= mem_req.rd;
			d_addr   <= mem_req.addr;
			rd_valid <= d_valid;
			rd_data  <= mem_byte(d_addr);
		end
	end

	initial
	begin
		#(watchdog_ns);
		$display("timeout: the run did not finish %0d frames in time", run_frames);
		$display("Test FAILED");
		$finish;
	end

	initial
	begin
		frames_seen = 0;
		// frame run_frames starts once frames 0 to run_frames-1 are done
		while (frames_seen < run_frames + 1)
		begin
			@(posedge clk);
			if (pix_out.valid && pix_out.frame_start)
				frames_seen++;
		end
		repeat (4)
			@(posedge clk);
		errors = i_video_top.i_video_checker.err_count;
		$display("frames: %0d, checker errors: %0d", frames_seen - 1, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
rtl/video_timing_pkg.sv
rtl/video_data_pkg.sv
rtl/video_timing.sv
rtl/video_fetch.sv
rtl/video_render.sv
rtl/video_top.sv
verification/video_checker.sv
verification/video_tb.sv

// File: Makefile
TOP = video_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -o sim

run: build
	@out=$$(./obj_dir/sim); status=$$?; echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir
